// File: common/prefetch_pkg.sv
// Prefetch buffer shared definitions
// Widths, bus request and response structs, controller state type

package prefetch_pkg;

  //////////////////////////////////////////////////
  // Widths and defaults
  //////////////////////////////////////////////////

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // Queue depth used by the top level unless overridden
  localparam int DEFAULT_FIFO_DEPTH = 2;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] word_t;

  //////////////////////////////////////////////////
  // Transaction structs
  //////////////////////////////////////////////////

  // Controller to bus port, one fetch request
  typedef struct packed {
    logic  valid;
    addr_t addr;
  } fetch_req_t;

  // Instruction bus request, address always word-aligned
  typedef struct packed {
    logic  req;
    addr_t addr;
  } bus_req_t;

  // Instruction bus response
  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    word_t rdata;
  } bus_rsp_t;

  // Fetch controller states
  typedef enum logic [1:0] {
    IDLE,
    WAIT_GNT,
    WAIT_RVALID,
    WAIT_ABORTED
  } ctrl_state_e;

endpackage

// File: prefetch/obi_fetch_port.sv
// Instruction bus master
// Holds each request stable until grant and tracks the single read in flight

`timescale 1ns/100ps

module obi_fetch_port import prefetch_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,

  // Controller side
  input  fetch_req_t fetch_req_i,
  output logic       trans_ready_o,
  output logic       rsp_valid_o,
  output word_t      rsp_rdata_o,

  // Bus side
  output bus_req_t   instr_bus_o,
  input  bus_rsp_t   instr_bus_i,

  output logic       busy_o
);

  // Request on the bus that has not been granted yet
  logic  pend_valid_q;
  addr_t pend_addr_q;

  logic  outstanding_q;
  // Granted read no longer wanted by the controller
  logic  drop_q;

  addr_t req_addr_aligned;
  logic  bus_gnt;
  logic  addr_match;

  assign req_addr_aligned = {fetch_req_i.addr[ADDR_W-1:2], 2'b00};

  // Registered copy wins while pending, else pass through
  // New reads wait for the one in flight to return
  always_comb begin
    if (pend_valid_q) begin
      instr_bus_o.req  = 1'b1;
      instr_bus_o.addr = pend_addr_q;
    end else begin
      instr_bus_o.req  = fetch_req_i.valid && (!outstanding_q || instr_bus_i.rvalid);
      instr_bus_o.addr = req_addr_aligned;
    end
  end

  assign bus_gnt    = instr_bus_o.req && instr_bus_i.gnt;
  assign addr_match = fetch_req_i.valid && (req_addr_aligned == instr_bus_o.addr);

  // Granted address must be the one the controller still wants
  assign trans_ready_o = bus_gnt && addr_match;

  assign rsp_valid_o = instr_bus_i.rvalid && outstanding_q && !drop_q;
  assign rsp_rdata_o = instr_bus_i.rdata;
  assign busy_o      = outstanding_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend_valid_q  <= 1'b0;
      outstanding_q <= 1'b0;
      drop_q        <= 1'b0;
    end else begin
      pend_valid_q <= instr_bus_o.req && !instr_bus_i.gnt;
      if (bus_gnt) begin
        outstanding_q <= 1'b1;
        drop_q        <= !addr_match;
      end else if (instr_bus_i.rvalid) begin
        outstanding_q <= 1'b0;
        drop_q        <= 1'b0;
      end
    end
  end

  // Address capture for a waited request
  always_ff @(posedge clk) begin
    if (instr_bus_o.req && !instr_bus_i.gnt) begin
      pend_addr_q <= instr_bus_o.addr;
    end
  end

endmodule

// File: prefetch/fetch_queue.sv
// Instruction queue
// Circular buffer with almost-full flag and empty-queue bypass

`timescale 1ns/100ps

module fetch_queue import prefetch_pkg::*; #(
  parameter int FIFO_DEPTH = DEFAULT_FIFO_DEPTH
) (
  input  logic  clk,
  input  logic  rst_n,

  input  logic  flush_i,
  input  logic  rsp_keep_i,
  input  word_t rsp_rdata_i,

  input  logic  fetch_ready_i,
  output logic  queue_ready_o,
  output logic  queue_valid_o,
  output logic  fetch_valid_o,
  output word_t fetch_rdata_o
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  word_t            mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] usage_q;

  logic push;
  logic pop;

  assign queue_valid_o = (usage_q != '0);
  // Almost full at one slot below depth
  assign queue_ready_o = (usage_q < CNT_W'(FIFO_DEPTH - 1));

  // Store unless it goes straight to a ready fetch stage
  assign push = rsp_keep_i && (queue_valid_o || !fetch_ready_i);
  assign pop  = queue_valid_o && fetch_ready_i;

  //////////////////////////////////////////////////
  // Output select
  //////////////////////////////////////////////////

  // Oldest stored word first, else the live response
  assign fetch_rdata_o = queue_valid_o ? mem_q[rd_ptr_q] : rsp_rdata_i;
  assign fetch_valid_o = !flush_i && (queue_valid_o || rsp_keep_i);

  //////////////////////////////////////////////////
  // Pointers and usage
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      usage_q  <= '0;
    end else if (flush_i) begin
      // Flush beats any push in the same cycle
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      usage_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        usage_q <= usage_q + 1'b1;
      end else if (pop && !push) begin
        usage_q <= usage_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push && !flush_i) begin
      mem_q[wr_ptr_q] <= rsp_rdata_i;
    end
  end

endmodule

// File: prefetch/prefetch_ctrl.sv
// Prefetch controller
// Picks the fetch address, issues bus reads and marks aborted responses

`timescale 1ns/100ps

module prefetch_ctrl import prefetch_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,

  input  logic       req_i,
  input  logic       branch_i,
  input  addr_t      branch_addr_i,

  // Queue has room for at least one more word
  input  logic       queue_ready_i,

  // Bus port handshake
  input  logic       trans_ready_i,
  input  logic       rsp_valid_i,
  output fetch_req_t fetch_req_o,

  // Response goes to the fetch stage or the queue
  output logic       rsp_keep_o
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  // Last issued address, raw branch target or sequential
  addr_t addr_q;
  addr_t next_addr;

  addr_t req_addr;
  logic  req_valid;
  logic  addr_update;

  // Sequential word after the last issued one
  assign next_addr = {addr_q[ADDR_W-1:2], 2'b00} + ADDR_W'(4);

  //////////////////////////////////////////////////
  // Next state and request
  //////////////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    req_addr    = next_addr;
    req_valid   = 1'b0;
    addr_update = 1'b0;
    rsp_keep_o  = rsp_valid_i;

    unique case (state_q)
      // Nothing on the bus
      IDLE: begin
        if (branch_i) begin
          req_addr = branch_addr_i;
        end
        if (branch_i || (req_i && queue_ready_i)) begin
          req_valid   = 1'b1;
          addr_update = 1'b1;
          state_d     = trans_ready_i ? WAIT_RVALID : WAIT_GNT;
        end
      end

      // Keep requesting until granted
      WAIT_GNT: begin
        req_valid   = 1'b1;
        req_addr    = branch_i ? branch_addr_i : addr_q;
        addr_update = branch_i;
        if (trans_ready_i) begin
          state_d = WAIT_RVALID;
        end
      end

      // One read in flight
      WAIT_RVALID: begin
        if (branch_i) begin
          req_addr = branch_addr_i;
        end
        if (rsp_valid_i) begin
          // Chain the next read onto the response cycle
          if (branch_i || (req_i && queue_ready_i)) begin
            req_valid   = 1'b1;
            addr_update = 1'b1;
            state_d     = trans_ready_i ? WAIT_RVALID : WAIT_GNT;
          end else begin
            state_d = IDLE;
          end
        end else if (branch_i) begin
          // Read in flight is now stale, remember the target
          addr_update = 1'b1;
          state_d     = WAIT_ABORTED;
        end
      end

      // Stale read in flight, drop its data
      WAIT_ABORTED: begin
        rsp_keep_o  = 1'b0;
        req_addr    = branch_i ? branch_addr_i : addr_q;
        addr_update = branch_i;
        if (rsp_valid_i) begin
          // Branch target goes out as the stale word returns
          req_valid = 1'b1;
          state_d   = trans_ready_i ? WAIT_RVALID : WAIT_GNT;
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  assign fetch_req_o.valid = req_valid;
  assign fetch_req_o.addr  = req_addr;

  //////////////////////////////////////////////////
  // State and address registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      addr_q  <= '0;
    end else begin
      state_q <= state_d;
      if (addr_update) begin
        addr_q <= req_addr;
      end
    end
  end

endmodule

// File: prefetch/prefetch_buffer.sv
// Instruction prefetch buffer top level
// Controller, instruction bus master and instruction queue

`timescale 1ns/100ps

module prefetch_buffer import prefetch_pkg::*; #(
  parameter int FIFO_DEPTH = DEFAULT_FIFO_DEPTH
) (
  input  logic     clk,
  input  logic     rst_n,

  // Core side
  input  logic     req_i,
  input  logic     branch_i,
  input  addr_t    branch_addr_i,
  input  logic     fetch_ready_i,
  output logic     fetch_valid_o,
  output word_t    fetch_rdata_o,

  // Instruction bus
  output bus_req_t instr_bus_o,
  input  bus_rsp_t instr_bus_i,

  // Outstanding bus read
  output logic     busy_o
);

  // Controller to bus port
  fetch_req_t fetch_req;
  logic       trans_ready;
  logic       rsp_valid;
  word_t      rsp_rdata;

  // Controller to queue
  logic       rsp_keep;
  logic       queue_ready;

  //////////////////////////////////////////////////
  // Fetch controller
  //////////////////////////////////////////////////

  prefetch_ctrl u_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .queue_ready_i (queue_ready),
    .trans_ready_i (trans_ready),
    .rsp_valid_i   (rsp_valid),
    .fetch_req_o   (fetch_req),
    .rsp_keep_o    (rsp_keep)
  );

  //////////////////////////////////////////////////
  // Bus master
  //////////////////////////////////////////////////

  obi_fetch_port u_bus_port (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_req_i   (fetch_req),
    .trans_ready_o (trans_ready),
    .rsp_valid_o   (rsp_valid),
    .rsp_rdata_o   (rsp_rdata),
    .instr_bus_o   (instr_bus_o),
    .instr_bus_i   (instr_bus_i),
    .busy_o        (busy_o)
  );

  //////////////////////////////////////////////////
  // Instruction queue
  //////////////////////////////////////////////////

  // A branch flushes everything fetched so far
  fetch_queue #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_queue (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush_i       (branch_i),
    .rsp_keep_i    (rsp_keep),
    .rsp_rdata_i   (rsp_rdata),
    .fetch_ready_i (fetch_ready_i),
    .queue_ready_o (queue_ready),
    .queue_valid_o (),
    .fetch_valid_o (fetch_valid_o),
    .fetch_rdata_o (fetch_rdata_o)
  );

endmodule

// File: tb/instr_mem_model.sv
// Instruction bus slave model
// Random grant and response delays, read data is the inverted address

`timescale 1ns/100ps

module instr_mem_model import prefetch_pkg::*; #(
  parameter int SEED = 94
) (
  input  logic     clk,
  input  logic     rst_n,
  input  bus_req_t bus_req_i,
  output bus_rsp_t bus_rsp_o
);

  int          seed;
  logic [31:0] rnd;

  // Cycles of request still to wait before grant
  logic [1:0]  gnt_wait_q;

  // Granted read waiting for its response
  logic        rsp_pend_q;
  logic [1:0]  rsp_wait_q;
  addr_t       rsp_addr_q;

  initial begin
    seed = SEED;
  end

  assign bus_rsp_o.gnt    = bus_req_i.req && (gnt_wait_q == 2'd0);
  assign bus_rsp_o.rvalid = rsp_pend_q && (rsp_wait_q == 2'd0);
  assign bus_rsp_o.rdata  = ~rsp_addr_q;

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt_wait_q <= 2'd0;
      rsp_pend_q <= 1'b0;
      rsp_wait_q <= 2'd0;
      rsp_addr_q <= '0;
    end else begin
      rnd = $random(seed);
      if (bus_rsp_o.gnt) begin
        // Next grant 0 to 3 cycles, this response 1 to 3 cycles out
        gnt_wait_q <= rnd[1:0];
        rsp_pend_q <= 1'b1;
        rsp_addr_q <= bus_req_i.addr;
        rsp_wait_q <= (rnd[3:2] == 2'd3) ? 2'd2 : rnd[3:2];
      end else begin
        if (bus_req_i.req && (gnt_wait_q != 2'd0)) begin
          gnt_wait_q <= gnt_wait_q - 2'd1;
        end
        if (bus_rsp_o.rvalid) begin
          rsp_pend_q <= 1'b0;
        end else if (rsp_pend_q && (rsp_wait_q != 2'd0)) begin
          rsp_wait_q <= rsp_wait_q - 2'd1;
        end
      end
    end
  end

endmodule

// File: tb/tb_prefetch.sv
// Testbench for the instruction prefetch buffer
// Drives the core side, models the bus, checks words, bus protocol and busy

`timescale 1ns/100ps

module tb_prefetch import prefetch_pkg::*; ();

  localparam int  FIFO_DEPTH = DEFAULT_FIFO_DEPTH;
  localparam int  SEED       = 94;
  localparam time DRIVE_DLY  = 10;
  // Limit well above the roughly 1500 cycles of the six tests
  localparam int  MAX_CYCLES = 4000;

  logic     clk;
  logic     rst_n       = 1'b0;
  logic     req         = 1'b0;
  logic     branch      = 1'b0;
  addr_t    branch_addr = '0;
  logic     fetch_ready = 1'b1;
  logic     fetch_valid;
  word_t    fetch_rdata;
  bus_req_t bus_req;
  bus_rsp_t bus_rsp;
  logic     busy;

  int    seed      = SEED;
  int    err_cnt   = 0;
  int    check_cnt = 0;
  int    consumed  = 0;
  int    cycles    = 0;
  int    test_num  = 0;
  int    test_err_base;
  string test_name;

  // Scoreboard state for the next word the core should see
  addr_t exp_addr  = '0;
  logic  exp_valid = 1'b0;

  prefetch_buffer #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) DUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req),
    .branch_i      (branch),
    .branch_addr_i (branch_addr),
    .fetch_ready_i (fetch_ready),
    .fetch_valid_o (fetch_valid),
    .fetch_rdata_o (fetch_rdata),
    .instr_bus_o   (bus_req),
    .instr_bus_i   (bus_rsp),
    .busy_o        (busy)
  );

  instr_mem_model #(
    .SEED (SEED)
  ) u_mem (
    .clk       (clk),
    .rst_n     (rst_n),
    .bus_req_i (bus_req),
    .bus_rsp_o (bus_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("ERROR: run stopped after %0d cycles without finishing", cycles);
      $display("test failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Reporting
  //////////////////////////////////////////////////

  task automatic report_error(input string msg);
    err_cnt++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  task automatic report_value(input string sig, input word_t got, input word_t exp);
    ctrl_state_e st;
    st = DUT.u_ctrl.state_q;
    err_cnt++;
    $display("FAIL %s got %h expected %h (ctrl %s at %0t)", sig, got, exp, st.name(), $time);
  endtask

  task automatic begin_test(input int num, input string name);
    test_num      = num;
    test_name     = name;
    test_err_base = err_cnt;
  endtask

  task automatic end_test();
    if (err_cnt == test_err_base) begin
      $display("[%0d] %s: ok", test_num, test_name);
    end else begin
      $display("[%0d] %s: %0d errors", test_num, test_name, err_cnt - test_err_base);
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  // Inputs change a short delay after the rising edge
  task automatic step();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic pulse_branch(input addr_t target);
    branch      = 1'b1;
    branch_addr = target;
    step();
    branch      = 1'b0;
  endtask

  // Run until n more words are consumed with optional random stalls and request gaps
  task automatic run_words(input int n, input logic rand_ready, input logic rand_req);
    int          target;
    logic [31:0] r;
    target = consumed + n;
    while (consumed < target) begin
      r           = $random(seed);
      fetch_ready = rand_ready ? r[0] : 1'b1;
      req         = rand_req ? (r[2:1] != 2'b00) : 1'b1;
      step();
    end
    fetch_ready = 1'b1;
    req         = 1'b1;
  endtask

  //////////////////////////////////////////////////
  // Scoreboard
  //////////////////////////////////////////////////

  // Sampled mid-cycle when inputs and DUT state have settled
  always @(negedge clk) begin
    if (rst_n) begin
      if (branch) begin
        exp_addr  = {branch_addr[ADDR_W-1:2], 2'b00};
        exp_valid = 1'b1;
      end else if (fetch_valid && fetch_ready) begin
        check_cnt++;
        consumed++;
        assert (exp_valid)
          else report_error("word consumed before any branch target was given");
        assert (fetch_rdata == ~exp_addr)
          else report_value("fetch_rdata_o", fetch_rdata, ~exp_addr);
        exp_addr = exp_addr + 32'd4;
      end
    end
  end

  //////////////////////////////////////////////////
  // Protocol checks
  //////////////////////////////////////////////////

  reset_low: assert property (@(posedge clk)
    !rst_n |-> (!bus_req.req && !fetch_valid && !busy))
    else report_error("request, valid or busy active during reset");

  addr_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    bus_req.req |-> (bus_req.addr[1:0] == 2'b00))
    else report_value("instr_bus_o.addr[1:0]", bus_req.addr[1:0], 32'h0);

  // Request and address held until grant
  req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (bus_req.req && !bus_rsp.gnt) |=> (bus_req.req && $stable(bus_req.addr)))
    else report_error("bus request dropped or changed before grant");

  busy_after_gnt: assert property (@(posedge clk) disable iff (!rst_n)
    (bus_req.req && bus_rsp.gnt) |=> busy)
    else report_error("busy_o low in the cycle after a grant");

  busy_held: assert property (@(posedge clk) disable iff (!rst_n)
    (busy && !bus_rsp.rvalid) |=> busy)
    else report_error("busy_o dropped before the read returned");

  busy_clear: assert property (@(posedge clk) disable iff (!rst_n)
    (!(bus_req.req && bus_rsp.gnt) && (!busy || bus_rsp.rvalid)) |=> !busy)
    else report_error("busy_o high with no read outstanding");

  // Almost full queue with nothing consumed blocks any new read
  no_gnt_when_full: assert property (@(posedge clk) disable iff (!rst_n)
    ((DUT.u_queue.usage_q == FIFO_DEPTH - 1) && !(fetch_valid && fetch_ready) && !branch
      && !$past(bus_req.req && !bus_rsp.gnt)) |-> !(bus_req.req && bus_rsp.gnt))
    else report_error("new read granted while the queue was almost full");

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  initial begin
    addr_t       target;
    logic [31:0] r;

    begin_test(1, "reset values");
    repeat (3) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
    step();
    assert (!bus_req.req && !fetch_valid && !busy)
      else report_error("request, valid or busy active right after reset");
    end_test();

    begin_test(2, "sequential fetch");
    req = 1'b1;
    pulse_branch(32'h0000_1000);
    run_words(40, 1'b0, 1'b0);
    end_test();

    begin_test(3, "back-pressure");
    pulse_branch(32'h0002_0ff4);
    run_words(60, 1'b1, 1'b0);
    end_test();

    begin_test(4, "branch redirect");
    for (int i = 0; i < 12; i++) begin
      r      = $random(seed);
      target = $random(seed);
      if (i[0]) begin
        // Redirect while a read is on the bus
        while (!busy) begin
          step();
        end
      end else begin
        repeat (r[2:0]) step();
      end
      pulse_branch(target);
      if (i == 5) begin
        pulse_branch(target + 32'h40);
      end
      run_words(4 + r[4:3], 1'b1, 1'b0);
    end
    end_test();

    begin_test(5, "bus protocol");
    // Sequence wraps through address zero
    pulse_branch(32'hffff_ff80);
    run_words(80, 1'b1, 1'b1);
    end_test();

    begin_test(6, "busy");
    req = 1'b0;
    while (busy || bus_req.req) begin
      step();
    end
    repeat (10) step();
    assert (!busy)
      else report_error("busy_o high while the bus is idle");
    req = 1'b1;
    pulse_branch(32'h0000_8002);
    run_words(20, 1'b0, 1'b1);
    end_test();

    $display("tests %0d, words checked %0d, errors %0d", test_num, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
common/prefetch_pkg.sv
prefetch/obi_fetch_port.sv
prefetch/fetch_queue.sv
prefetch/prefetch_ctrl.sv
prefetch/prefetch_buffer.sv
tb/instr_mem_model.sv
tb/tb_prefetch.sv

// File: Makefile
TOOL     := verilator
TOP      := tb_prefetch
FILELIST := vlog.f
FLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP)
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
